//--- Makefile
# Verilator build and run for the RV64I decode stage testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module decode_tb \
		-f compile.f -Mdir obj_dir -o decode_tb

# The error limit keeps the run going after an assertion failure.
run: compile
	./obj_dir/decode_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
rtl/id_pkg.sv
rtl/regfile.sv
rtl/imm_gen.sv
rtl/inst_decoder.sv
rtl/id_stage.sv
rtl/decode_top.sv
testbench/decode_assert.sv
testbench/decode_tb.sv

//--- rtl/decode_top.sv
/* Top level: register file read feeding the decode stage,
   with the write-back port into the register file. */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // Fetch side.
  input  wire logic                          fetched_req_i,
  input  id_pkg::fetch_t                     fetch_i,
  // Write-back side.
  input  wire logic                          wb_wen_i,
  input  wire logic [id_pkg::reg_addr_w-1:0] wb_rd_i,
  input  wire logic [id_pkg::xlen-1:0]       wb_data_i,
  // Downstream side.
  input  wire logic                          decoded_ack_i,
  output logic                               decoded_req_o,
  output id_pkg::decode_t                    decode_o
);

  logic [id_pkg::reg_addr_w-1:0] rs1_addr;
  logic [id_pkg::reg_addr_w-1:0] rs2_addr;
  logic [id_pkg::xlen-1:0]       rs1_data;
  logic [id_pkg::xlen-1:0]       rs2_data;

  // Source fields are read straight from the incoming instruction.
  assign rs1_addr = fetch_i.inst[19:15];
  assign rs2_addr = fetch_i.inst[24:20];

  regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wen_i      (wb_wen_i),
    .waddr_i    (wb_rd_i),
    .wdata_i    (wb_data_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  id_stage u_id_stage (
    .clk           (clk),
    .rst           (rst),
    .fetched_req_i (fetched_req_i),
    .fetch_i       (fetch_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .decoded_ack_i (decoded_ack_i),
    .decoded_req_o (decoded_req_o),
    .decode_o      (decode_o)
  );

endmodule

`default_nettype wire

//--- rtl/id_pkg.sv
/* Shared widths, opcode and format enums, and the fetch and decode structs
   for the RV64I decode stage. */
`default_nettype none

package id_pkg;

  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  // Values are the ISA major opcodes.
  typedef enum logic [6:0] {
    op_illegal = 7'b0000000,
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_branch  = 7'b1100011,
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_imm     = 7'b0010011,
    op_op      = 7'b0110011,
    op_imm_32  = 7'b0011011,
    op_op_32   = 7'b0111011
  } opcode_e;

  typedef enum logic [2:0] {
    fmt_r    = 3'd0,
    fmt_i    = 3'd1,
    fmt_s    = 3'd2,
    fmt_b    = 3'd3,
    fmt_u    = 3'd4,
    fmt_j    = 3'd5,
    fmt_none = 3'd6
  } itype_e;

  typedef struct packed {
    logic [ilen-1:0] inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_pred;
  } fetch_t;

  typedef struct packed {
    itype_e                itype;
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic                  rs1_ren;
    logic                  rs2_ren;
    logic                  memren;
    logic                  memwen;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    logic [xlen-1:0]       t1;
    logic [xlen-1:0]       memaddr;
    logic [xlen-1:0]       memwdata;
    logic [xlen-1:0]       pc_pred;
  } decode_t;

endpackage

`default_nettype wire

//--- rtl/id_stage.sv
/* Decode stage: fetch latch, decoded request handshake and decoder. */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    fetched_req_i,
  input  id_pkg::fetch_t               fetch_i,
  input  wire logic [id_pkg::xlen-1:0] rs1_data_i,
  input  wire logic [id_pkg::xlen-1:0] rs2_data_i,
  input  wire logic                    decoded_ack_i,
  output logic                         decoded_req_o,
  output id_pkg::decode_t              decode_o
);

  id_pkg::fetch_t          fetch_q;
  logic [id_pkg::xlen-1:0] rs1_q;
  logic [id_pkg::xlen-1:0] rs2_q;

  // A zero instruction decodes as illegal, so the cleared latch is inert.
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= '0;
      rs1_q   <= '0;
      rs2_q   <= '0;
    end else if (fetched_req_i) begin
      fetch_q <= fetch_i;
      rs1_q   <= rs1_data_i;
      rs2_q   <= rs2_data_i;
    end
  end

  // New fetch wins over an acknowledge.
  always_ff @(posedge clk) begin
    if (rst) begin
      decoded_req_o <= 1'b0;
    end else if (fetched_req_i) begin
      decoded_req_o <= 1'b1;
    end else if (decoded_ack_i) begin
      decoded_req_o <= 1'b0;
    end
  end

  inst_decoder u_inst_decoder (
    .inst_i     (fetch_q.inst),
    .pc_i       (fetch_q.pc),
    .pc_pred_i  (fetch_q.pc_pred),
    .rs1_data_i (rs1_q),
    .rs2_data_i (rs2_q),
    .dec_o      (decode_o)
  );

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
/* Immediate extraction for the I, S, B, U and J formats,
   sign-extended to 64 bits. */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  wire logic [id_pkg::ilen-1:0] inst_i,
  output logic      [id_pkg::xlen-1:0] imm_i_o,
  output logic      [id_pkg::xlen-1:0] imm_s_o,
  output logic      [id_pkg::xlen-1:0] imm_b_o,
  output logic      [id_pkg::xlen-1:0] imm_u_o,
  output logic      [id_pkg::xlen-1:0] imm_j_o
);

  logic sign;

  assign sign = inst_i[31];

  assign imm_i_o = {{52{sign}}, inst_i[31:20]};

  assign imm_s_o = {{52{sign}}, inst_i[31:25], inst_i[11:7]};

  // Branch offsets are in units of two bytes.
  assign imm_b_o = {
    {51{sign}},
    inst_i[31],
    inst_i[7],
    inst_i[30:25],
    inst_i[11:8],
    1'b0
  };

  assign imm_u_o = {{32{sign}}, inst_i[31:12], 12'b0};

  assign imm_j_o = {
    {43{sign}},
    inst_i[31],
    inst_i[19:12],
    inst_i[20],
    inst_i[30:21],
    1'b0
  };

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
/* Combinational RV64I decoder: opcode and format classification,
   operand selection, memory controls and jump or branch targets. */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  wire logic [id_pkg::ilen-1:0] inst_i,
  input  wire logic [id_pkg::xlen-1:0] pc_i,
  input  wire logic [id_pkg::xlen-1:0] pc_pred_i,
  input  wire logic [id_pkg::xlen-1:0] rs1_data_i,
  input  wire logic [id_pkg::xlen-1:0] rs2_data_i,
  output id_pkg::decode_t              dec_o
);

  logic [id_pkg::xlen-1:0] imm_i;
  logic [id_pkg::xlen-1:0] imm_s;
  logic [id_pkg::xlen-1:0] imm_b;
  logic [id_pkg::xlen-1:0] imm_u;
  logic [id_pkg::xlen-1:0] imm_j;
  logic [id_pkg::xlen-1:0] rs1_plus_i;
  logic [id_pkg::xlen-1:0] rs1_plus_s;
  logic [id_pkg::xlen-1:0] pc_plus_b;
  logic [id_pkg::xlen-1:0] pc_plus_j;
  id_pkg::opcode_e         opc;

  imm_gen u_imm_gen (
    .inst_i  (inst_i),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_b_o (imm_b),
    .imm_u_o (imm_u),
    .imm_j_o (imm_j)
  );

  assign rs1_plus_i = rs1_data_i + imm_i;
  assign rs1_plus_s = rs1_data_i + imm_s;
  assign pc_plus_b  = pc_i + imm_b;
  assign pc_plus_j  = pc_i + imm_j;

  // Anything outside the supported major opcodes is illegal.
  always_comb begin
    case (inst_i[6:0])
      id_pkg::op_lui, id_pkg::op_auipc, id_pkg::op_jal, id_pkg::op_jalr,
      id_pkg::op_branch, id_pkg::op_load, id_pkg::op_store, id_pkg::op_imm,
      id_pkg::op_op, id_pkg::op_imm_32, id_pkg::op_op_32:
        opc = id_pkg::opcode_e'(inst_i[6:0]);
      default:
        opc = id_pkg::op_illegal;
    endcase
  end

  always_comb begin
    dec_o         = '0;
    dec_o.itype   = id_pkg::fmt_none;
    dec_o.opcode  = opc;
    dec_o.pc_pred = pc_pred_i;
    if (opc != id_pkg::op_illegal) begin
      dec_o.funct3 = inst_i[14:12];
      dec_o.funct7 = inst_i[31:25];
      dec_o.rd     = inst_i[11:7];
    end
    case (opc)
      id_pkg::op_lui: begin
        dec_o.itype = id_pkg::fmt_u;
        dec_o.op2   = imm_u;
      end
      id_pkg::op_auipc: begin
        dec_o.itype = id_pkg::fmt_u;
        dec_o.op1   = pc_i;
        dec_o.op2   = imm_u;
      end
      id_pkg::op_jal: begin
        dec_o.itype = id_pkg::fmt_j;
        dec_o.op1   = pc_i;
        dec_o.op2   = 64'd4;
        dec_o.t1    = pc_plus_j;
      end
      id_pkg::op_jalr: begin
        dec_o.itype   = id_pkg::fmt_i;
        dec_o.rs1_ren = 1'b1;
        dec_o.op1     = pc_i;
        dec_o.op2     = 64'd4;
        dec_o.t1      = {rs1_plus_i[id_pkg::xlen-1:1], 1'b0};
      end
      id_pkg::op_branch: begin
        // No destination register.
        dec_o.itype   = id_pkg::fmt_b;
        dec_o.rd      = '0;
        dec_o.rs1_ren = 1'b1;
        dec_o.rs2_ren = 1'b1;
        dec_o.op1     = rs1_data_i;
        dec_o.op2     = rs2_data_i;
        dec_o.t1      = pc_plus_b;
      end
      id_pkg::op_load: begin
        dec_o.itype   = id_pkg::fmt_i;
        dec_o.rs1_ren = 1'b1;
        dec_o.memren  = 1'b1;
        dec_o.op1     = rs1_data_i;
        dec_o.op2     = imm_i;
        dec_o.memaddr = rs1_plus_i;
      end
      id_pkg::op_store: begin
        dec_o.itype    = id_pkg::fmt_s;
        dec_o.rd       = '0;
        dec_o.rs1_ren  = 1'b1;
        dec_o.rs2_ren  = 1'b1;
        dec_o.memwen   = 1'b1;
        dec_o.op1      = rs1_data_i;
        dec_o.op2      = imm_s;
        dec_o.memaddr  = rs1_plus_s;
        dec_o.memwdata = rs2_data_i;
      end
      id_pkg::op_imm, id_pkg::op_imm_32: begin
        dec_o.itype   = id_pkg::fmt_i;
        dec_o.rs1_ren = 1'b1;
        dec_o.op1     = rs1_data_i;
        dec_o.op2     = imm_i;
      end
      id_pkg::op_op, id_pkg::op_op_32: begin
        dec_o.itype   = id_pkg::fmt_r;
        dec_o.rs1_ren = 1'b1;
        dec_o.rs2_ren = 1'b1;
        dec_o.op1     = rs1_data_i;
        dec_o.op2     = rs2_data_i;
      end
      default: begin
        dec_o.itype = id_pkg::fmt_none;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
/* Integer register file, 32 x 64 bits, two async read ports, one write port. */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [id_pkg::reg_addr_w-1:0] rs1_addr_i,
  input  wire logic [id_pkg::reg_addr_w-1:0] rs2_addr_i,
  input  wire logic                          wen_i,
  input  wire logic [id_pkg::reg_addr_w-1:0] waddr_i,
  input  wire logic [id_pkg::xlen-1:0]       wdata_i,
  output logic      [id_pkg::xlen-1:0]       rs1_data_o,
  output logic      [id_pkg::xlen-1:0]       rs2_data_o
);

  logic [id_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired to zero.
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- testbench/decode_assert.sv
/* Handshake, reset and memory control assertions, bound into decode_top. */
`timescale 1ns/1ps
`default_nettype none

module decode_assert (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       fetched_req_i,
  input wire logic       decoded_ack_i,
  input wire logic       decoded_req_i,
  input id_pkg::decode_t decode_i
);

  int unsigned fail_cnt = 0;

  // A fetch is always accepted.
  a_fetch_sets_req: assert property (
    @(posedge clk) disable iff (rst) fetched_req_i |=> decoded_req_i
  ) else begin
    fail_cnt++;
    $error("decoded request not raised after a fetch strobe");
  end

  a_req_falls_on_ack: assert property (
    @(posedge clk) disable iff (rst)
    $fell(decoded_req_i) |-> $past(decoded_ack_i && !fetched_req_i)
  ) else begin
    fail_cnt++;
    $error("decoded request dropped without an acknowledge");
  end

  a_mem_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(decode_i.memren && decode_i.memwen)
  ) else begin
    fail_cnt++;
    $error("memory read and write enables high together");
  end

  a_req_low_in_reset: assert property (
    @(posedge clk) rst |=> !decoded_req_i
  ) else begin
    fail_cnt++;
    $error("decoded request high during reset");
  end

endmodule

bind decode_top decode_assert u_assert (
  .clk           (clk),
  .rst           (rst),
  .fetched_req_i (fetched_req_i),
  .decoded_ack_i (decoded_ack_i),
  .decoded_req_i (decoded_req_o),
  .decode_i      (decode_o)
);

`default_nettype wire

//--- testbench/decode_tb.sv
/* Testbench for the decode top level: handshake, operands, memory controls
   and targets, checked against a shadow register file. */
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

  logic            clk;
  logic            rst;
  logic            fetched_req;
  id_pkg::fetch_t  fetch;
  logic            wb_wen;
  logic [4:0]      wb_rd;
  logic [63:0]     wb_data;
  logic            decoded_ack;
  logic            decoded_req;
  id_pkg::decode_t decode;
  logic [63:0]     shadow [32];
  int              errors;
  int              test_errors;
  int              tests;

  decode_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .fetched_req_i (fetched_req),
    .fetch_i       (fetch),
    .wb_wen_i      (wb_wen),
    .wb_rd_i       (wb_rd),
    .wb_data_i     (wb_data),
    .decoded_ack_i (decoded_ack),
    .decoded_req_o (decoded_req),
    .decode_o      (decode)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // All tests take about 300 cycles.
  initial begin
    repeat (2000) @(posedge clk);
    $display("timeout: tests did not complete within 2000 cycles");
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Fields every legal decode copies from the instruction.
  function automatic id_pkg::decode_t base_exp(input logic [31:0] inst,
                                               input id_pkg::itype_e fmt,
                                               input logic [63:0] pc_pred);
    id_pkg::decode_t d;
    d         = '0;
    d.itype   = fmt;
    d.opcode  = id_pkg::opcode_e'(inst[6:0]);
    d.funct3  = inst[14:12];
    d.funct7  = inst[31:25];
    d.rd      = inst[11:7];
    d.pc_pred = pc_pred;
    return d;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_decode(input id_pkg::decode_t e);
    check_val("decode_o.itype", 64'(decode.itype), 64'(e.itype));
    check_val("decode_o.opcode", 64'(decode.opcode), 64'(e.opcode));
    check_val("decode_o.funct3", 64'(decode.funct3), 64'(e.funct3));
    check_val("decode_o.funct7", 64'(decode.funct7), 64'(e.funct7));
    check_val("decode_o.rd", 64'(decode.rd), 64'(e.rd));
    check_val("decode_o.rs1_ren", 64'(decode.rs1_ren), 64'(e.rs1_ren));
    check_val("decode_o.rs2_ren", 64'(decode.rs2_ren), 64'(e.rs2_ren));
    check_val("decode_o.memren", 64'(decode.memren), 64'(e.memren));
    check_val("decode_o.memwen", 64'(decode.memwen), 64'(e.memwen));
    check_val("decode_o.op1", decode.op1, e.op1);
    check_val("decode_o.op2", decode.op2, e.op2);
    check_val("decode_o.t1", decode.t1, e.t1);
    check_val("decode_o.memaddr", decode.memaddr, e.memaddr);
    check_val("decode_o.memwdata", decode.memwdata, e.memwdata);
    check_val("decode_o.pc_pred", decode.pc_pred, e.pc_pred);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    @(posedge clk);
    wb_wen  <= 1'b1;
    wb_rd   <= addr;
    wb_data <= data;
    @(posedge clk);
    wb_wen <= 1'b0;
    if (addr != 5'd0) begin
      shadow[addr] = data;
    end
  endtask

  // Ends at the falling edge after the DUT has taken the fetch.
  task automatic send_fetch(input logic [31:0] inst, input logic [63:0] pc,
                            input logic [63:0] pc_pred, input logic ack);
    @(posedge clk);
    fetched_req   <= 1'b1;
    decoded_ack   <= ack;
    fetch.inst    <= inst;
    fetch.pc      <= pc;
    fetch.pc_pred <= pc_pred;
    @(posedge clk);
    fetched_req <= 1'b0;
    decoded_ack <= 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    tests++;
    errors += test_errors;
    $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  initial begin
    id_pkg::decode_t exp;
    logic [31:0]     rnd;
    logic [31:0]     inst;
    logic [11:0]     imm;
    logic [12:0]     bimm;
    logic [20:0]     jimm;
    logic [19:0]     uimm;
    logic [4:0]      s1;
    logic [4:0]      s2;
    logic [4:0]      dst;
    logic [63:0]     pc;
    logic [63:0]     pp;
    void'($urandom(32'h63f1820b));
    rst         <= 1'b1;
    fetched_req <= 1'b0;
    fetch       <= '0;
    wb_wen      <= 1'b0;
    wb_rd       <= '0;
    wb_data     <= '0;
    decoded_ack <= 1'b0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_val("decoded_req_o", 64'(decoded_req), 64'd0);
    exp        = '0;
    exp.itype  = id_pkg::fmt_none;
    exp.opcode = id_pkg::op_illegal;
    compare_decode(exp);
    finish_test("reset");

    // The write to x0 must be dropped.
    for (int i = 0; i < 32; i++) begin
      write_reg(5'(i), {$urandom, $urandom});
    end

    inst = enc_i(12'h005, 5'd1, 3'b000, 5'd2, id_pkg::op_imm);
    send_fetch(inst, 64'h1000, 64'h1004, 1'b0);
    check_val("decoded_req_o", 64'(decoded_req), 64'd1);
    repeat (3) @(negedge clk);
    check_val("decoded_req_o", 64'(decoded_req), 64'd1);
    @(posedge clk);
    decoded_ack <= 1'b1;
    @(posedge clk);
    decoded_ack <= 1'b0;
    @(negedge clk);
    check_val("decoded_req_o", 64'(decoded_req), 64'd0);
    send_fetch(inst, 64'h1000, 64'h1004, 1'b0);
    inst = enc_i(12'h7ff, 5'd3, 3'b000, 5'd4, id_pkg::op_imm);
    send_fetch(inst, 64'h1004, 64'h1008, 1'b1);
    check_val("decoded_req_o", 64'(decoded_req), 64'd1);
    exp         = base_exp(inst, id_pkg::fmt_i, 64'h1008);
    exp.rs1_ren = 1'b1;
    exp.op1     = shadow[3];
    exp.op2     = 64'h7ff;
    compare_decode(exp);
    finish_test("handshake");

    for (int i = 0; i < 20; i++) begin
      rnd = $urandom;
      s1  = (i == 0) ? 5'd0 : rnd[4:0];
      s2  = rnd[9:5];
      dst = rnd[14:10];
      imm = rnd[31:20];
      if (i % 2 == 0) begin
        imm[11] = 1'b1;
      end
      pp = {$urandom, $urandom};
      if (rnd[15]) begin
        inst = enc_r(rnd[31:25], s2, s1, rnd[18:16], dst,
                     rnd[19] ? id_pkg::op_op_32 : id_pkg::op_op);
        exp         = base_exp(inst, id_pkg::fmt_r, pp);
        exp.rs2_ren = 1'b1;
        exp.op2     = shadow[s2];
      end else begin
        inst = enc_i(imm, s1, rnd[18:16], dst,
                     rnd[19] ? id_pkg::op_imm_32 : id_pkg::op_imm);
        exp     = base_exp(inst, id_pkg::fmt_i, pp);
        exp.op2 = sext12(imm);
      end
      exp.rs1_ren = 1'b1;
      exp.op1     = shadow[s1];
      send_fetch(inst, {$urandom, $urandom}, pp, 1'b0);
      compare_decode(exp);
    end
    finish_test("alu");

    for (int i = 0; i < 10; i++) begin
      rnd = $urandom;
      s1  = rnd[4:0];
      s2  = rnd[9:5];
      dst = rnd[14:10];
      imm = rnd[31:20];
      pp  = {$urandom, $urandom};
      if (i % 2 == 0) begin
        inst = enc_i(imm, s1, rnd[17:15], dst, id_pkg::op_load);
        exp        = base_exp(inst, id_pkg::fmt_i, pp);
        exp.memren = 1'b1;
      end else begin
        inst = {imm[11:5], s2, s1, rnd[17:15], imm[4:0], id_pkg::op_store};
        exp          = base_exp(inst, id_pkg::fmt_s, pp);
        exp.rd       = '0;
        exp.rs2_ren  = 1'b1;
        exp.memwen   = 1'b1;
        exp.memwdata = shadow[s2];
      end
      exp.rs1_ren = 1'b1;
      exp.op1     = shadow[s1];
      exp.op2     = sext12(imm);
      exp.memaddr = shadow[s1] + sext12(imm);
      send_fetch(inst, {$urandom, $urandom}, pp, 1'b0);
      compare_decode(exp);
    end
    finish_test("memory");

    for (int i = 0; i < 4; i++) begin
      rnd  = $urandom;
      s1   = rnd[4:0];
      s2   = rnd[9:5];
      dst  = rnd[14:10];
      imm  = rnd[31:20];
      uimm = rnd[31:12];
      bimm = {rnd[31:20], 1'b0};
      jimm = {rnd[31:12], 1'b0};
      pc   = {$urandom, $urandom};
      pp   = {$urandom, $urandom};

      inst = {uimm, dst, id_pkg::op_lui};
      exp     = base_exp(inst, id_pkg::fmt_u, pp);
      exp.op2 = {{32{uimm[19]}}, uimm, 12'b0};
      send_fetch(inst, pc, pp, 1'b0);
      compare_decode(exp);

      inst = {uimm, dst, id_pkg::op_auipc};
      exp     = base_exp(inst, id_pkg::fmt_u, pp);
      exp.op1 = pc;
      exp.op2 = {{32{uimm[19]}}, uimm, 12'b0};
      send_fetch(inst, pc, pp, 1'b0);
      compare_decode(exp);

      inst = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], dst, id_pkg::op_jal};
      exp     = base_exp(inst, id_pkg::fmt_j, pp);
      exp.op1 = pc;
      exp.op2 = 64'd4;
      exp.t1  = pc + {{43{jimm[20]}}, jimm};
      send_fetch(inst, pc, pp, 1'b0);
      compare_decode(exp);

      inst = enc_i(imm, s1, 3'b000, dst, id_pkg::op_jalr);
      exp         = base_exp(inst, id_pkg::fmt_i, pp);
      exp.rs1_ren = 1'b1;
      exp.op1     = pc;
      exp.op2     = 64'd4;
      exp.t1      = (shadow[s1] + sext12(imm)) & ~64'd1;
      send_fetch(inst, pc, pp, 1'b0);
      compare_decode(exp);

      inst = {bimm[12], bimm[10:5], s2, s1, rnd[17:15], bimm[4:1], bimm[11],
              id_pkg::op_branch};
      exp         = base_exp(inst, id_pkg::fmt_b, pp);
      exp.rd      = '0;
      exp.rs1_ren = 1'b1;
      exp.rs2_ren = 1'b1;
      exp.op1     = shadow[s1];
      exp.op2     = shadow[s2];
      exp.t1      = pc + {{51{bimm[12]}}, bimm};
      send_fetch(inst, pc, pp, 1'b0);
      compare_decode(exp);
    end
    finish_test("control");

    // CSR and fence opcodes are outside the supported set.
    for (int i = 0; i < 2; i++) begin
      rnd  = $urandom;
      pp   = {$urandom, $urandom};
      inst = {rnd[31:7], (i == 0) ? 7'b1110011 : 7'b0001111};
      exp         = '0;
      exp.itype   = id_pkg::fmt_none;
      exp.opcode  = id_pkg::op_illegal;
      exp.pc_pred = pp;
      send_fetch(inst, {$urandom, $urandom}, pp, 1'b0);
      compare_decode(exp);
    end
    finish_test("illegal");

    // Reset while an item is held clears the request and the latch.
    inst = enc_i(12'h001, 5'd1, 3'b000, 5'd1, id_pkg::op_imm);
    send_fetch(inst, 64'h2000, 64'h2004, 1'b0);
    check_val("decoded_req_o", 64'(decoded_req), 64'd1);
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("decoded_req_o", 64'(decoded_req), 64'd0);
    exp        = '0;
    exp.itype  = id_pkg::fmt_none;
    exp.opcode = id_pkg::op_illegal;
    compare_decode(exp);
    finish_test("held_reset");

    $display("%0d tests run, %0d check errors, %0d assertion failures",
             tests, errors, u_dut.u_assert.fail_cnt);
    if (errors == 0 && u_dut.u_assert.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
